/* program.hex */
// one instruction word per line, word address 0 first
// fields are op[31:26] rs[25:21] rt[20:16] rd[15:11] imm[15:0]
20010005 // addi r1, r0, 5
20220007 // addi r2, r1, 7
04411800 // sub  r3, r2, r1
04232000 // sub  r4, r1, r3
ac040100 // sw   r4, 0x100(r0)
ac030104 // sw   r3, 0x104(r0)
10812800 // slt  r5, r4, r1
0ca23000 // or   r6, r5, r2
ac060108 // sw   r6, 0x108(r0)
8c070010 // lw   r7, 0x10(r0)
20e80003 // addi r8, r7, 3
ac08010c // sw   r8, 0x10c(r0)
40220002 // beq  r1, r2, +2 (not taken)
ac010110 // sw   r1, 0x110(r0)
2009000c // addi r9, r0, 12
41220002 // beq  r9, r2, +2 (taken)
ac0101f0 // sw   r1, 0x1f0(r0), flushed
ac0201f4 // sw   r2, 0x1f4(r0), flushed
ac090114 // sw   r9, 0x114(r0)
48000016 // j    22
ac0101f8 // sw   r1, 0x1f8(r0), flushed
ac0201fc // sw   r2, 0x1fc(r0), flushed
ac050118 // sw   r5, 0x118(r0)
fc000000 // halt

/* sources.f */
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
instruction_memory.sv
decode_unit.sv
register_file.sv
hazard_forward_unit.sv
alu.sv
processor.sv
tb_clock_gen.sv
processor_sva.sv
tb_processor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the processor testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_processor \
  -o sim_processor

./obj_dir/sim_processor > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tb_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_processor;

  localparam int          RESET_CYCLES   = 3;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          QUIET_CYCLES   = 20;
  localparam int          MEM_WORDS      = 256;
  localparam int          STORE_COUNT    = 7;
  localparam logic [31:0] SEED           = 32'd25249;

  // stores in program order as worked out by hand from program.hex
  localparam cpu_isa_pkg::addr_t EXP_ADDR [STORE_COUNT] = '{
    32'h0000_0100, 32'h0000_0104, 32'h0000_0108, 32'h0000_010c,
    32'h0000_0110, 32'h0000_0114, 32'h0000_0118
  };
  localparam cpu_isa_pkg::data_t EXP_DATA [STORE_COUNT] = '{
    32'hffff_fffe,  // 5 - 7
    32'h0000_0007,  // 12 - 5
    32'h0000_000d,  // (-2 < 5) | 12
    32'hc004_fb07,  // word 4 of the fill pattern plus 3
    32'h0000_0005,  // after the untaken beq
    32'h0000_000c,  // beq target
    32'h0000_0001   // jump target
  };

  logic                  clk;
  logic                  reset;
  cpu_pipe_pkg::wb_req_t wb_req;
  cpu_isa_pkg::data_t    wb_dat_r = '0;
  logic                  wb_ack = 1'b0;
  logic                  halted;

  // wishbone slave state
  cpu_isa_pkg::data_t mem [MEM_WORDS];
  int                 stores_seen = 0;
  logic               wait_armed = 1'b0;
  logic [1:0]         wait_left = '0;
  logic [31:0]        rng_state = SEED;

  tb_clock_gen clock_i (
    .clk (clk)
  );

  processor processor_i (
    .clk      (clk),
    .reset    (reset),
    .wb_req   (wb_req),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .halted   (halted)
  );

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // the low bytes carry the word index so no two words match
  function automatic cpu_isa_pkg::data_t fill_word(input logic [7:0] idx);
    return {8'hc0, idx, ~idx, idx};
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    $display("ERR t=%0t %s got=%h expected=%h", $time, name, got, expected);
    stop_run();
  endtask

  task automatic fail_event(input string what);
    $display("error at t=%0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_store(input cpu_isa_pkg::addr_t adr, input cpu_isa_pkg::data_t dat);
    assert (stores_seen < STORE_COUNT) else fail_event("more stores than the program holds");
    assert (adr == EXP_ADDR[stores_seen])
      else fail_value("wb_req.adr", adr, EXP_ADDR[stores_seen]);
    assert (dat == EXP_DATA[stores_seen])
      else fail_value("wb_req.dat_w", dat, EXP_DATA[stores_seen]);
    stores_seen = stores_seen + 1;
  endtask

  task automatic answer_request();
    logic [7:0] idx;
    idx = wb_req.adr[9:2];
    assert (wb_req.adr[31:10] == '0 && wb_req.adr[1:0] == '0)
      else fail_event("bus address outside the memory model");
    wb_ack <= 1'b1;
    if (wb_req.we) begin
      check_store(wb_req.adr, wb_req.dat_w);
      mem[idx] <= wb_req.dat_w;
    end else begin
      wb_dat_r <= mem[idx];
    end
  endtask

  //////////////////////////////////////////////////
  // wishbone slave with 0 to 3 wait states

  always @(posedge clk) begin
    if (reset) begin
      wb_ack     <= 1'b0;
      wait_armed <= 1'b0;
      wait_left  <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= fill_word(8'(i));
      end
    end else if (wb_ack) begin
      wb_ack     <= 1'b0;
      wait_armed <= 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!wait_armed) begin
        // the program opens with stores before its only load
        assert (stores_seen > 0 || wb_req.we) else fail_event("first bus cycle is not a store");
        rng_state = xorshift32(rng_state);
        wait_armed <= 1'b1;
        wait_left  <= rng_state[1:0];
        if (rng_state[1:0] == 2'd0) begin
          answer_request();
        end
      end else if (wait_left <= 2'd1) begin
        answer_request();
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

  // no bus traffic once the core has stopped
  always @(posedge clk) begin
    if (!reset) begin
      assert (!(halted && wb_req.cyc)) else fail_event("bus cycle after halted");
    end
  end

  //////////////////////////////////////////////////
  // reset, run to halt, final count

  initial begin
    int cycles;
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    assert (!wb_req.cyc && !wb_req.stb && !halted)
      else fail_event("bus or halted active right after reset");

    cycles = 0;
    while (!halted && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    assert (halted) else fail_event("timeout waiting for halted");

    // keep watching the bus for a while after halt
    repeat (QUIET_CYCLES) @(posedge clk);

    if (stores_seen == STORE_COUNT) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      fail_value("stores_seen", 32'(stores_seen), 32'(STORE_COUNT));
    end
  end

endmodule

`default_nettype wire

/* processor_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module processor_sva (
  input logic                  clk,
  input logic                  reset,
  input cpu_pipe_pkg::wb_req_t wb_req,
  input logic                  wb_ack,
  input logic                  halted
);

  // stb only inside a bus cycle
  stb_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb |-> wb_req.cyc)
    else $error("wb stb high while cyc is low");

  // request fields held while the slave inserts wait states
  req_stable: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb && !wb_ack |=>
      wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we) && $stable(wb_req.dat_w))
    else $error("wb request changed before ack");

  // cycle ends right after ack
  release_after_ack: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb && wb_ack |=> !wb_req.stb && !wb_req.cyc)
    else $error("wb cycle still open after ack");

  // halted is sticky
  halted_sticky: assert property (@(posedge clk)
    halted && !reset |=> halted)
    else $error("halted fell without reset");

endmodule

bind processor processor_sva processor_sva_i (
  .clk    (clk),
  .reset  (reset),
  .wb_req (wb_req),
  .wb_ack (wb_ack),
  .halted (halted)
);

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // 40 ns period
  localparam int HALF_PERIOD_NS = 20;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* processor.sv */
`timescale 1ns/100ps
`default_nettype none

module processor (
  input  logic                  clk,
  input  logic                  reset,
  output cpu_pipe_pkg::wb_req_t wb_req,
  input  cpu_isa_pkg::data_t    wb_dat_r,
  input  logic                  wb_ack,
  output logic                  halted
);

  typedef enum logic [1:0] {IDLE, BUS, DONE} bus_state_e;

  cpu_isa_pkg::addr_t     pc;
  cpu_isa_pkg::addr_t     pc_plus4;
  cpu_isa_pkg::inst_t     fetch_inst;
  cpu_pipe_pkg::if_id_t   if_id;
  cpu_pipe_pkg::id_ex_t   id_ex;
  cpu_pipe_pkg::ex_mem_t  ex_mem;
  cpu_pipe_pkg::mem_wb_t  mem_wb;
  cpu_pipe_pkg::ctrl_t    id_ctrl;
  cpu_isa_pkg::reg_idx_t  id_rs;
  cpu_isa_pkg::reg_idx_t  id_rt;
  cpu_isa_pkg::reg_idx_t  id_rd;
  cpu_isa_pkg::imm_t      id_imm;
  cpu_isa_pkg::data_t     reg_data_1;
  cpu_isa_pkg::data_t     reg_data_2;
  cpu_pipe_pkg::fwd_sel_e forward_a;
  cpu_pipe_pkg::fwd_sel_e forward_b;
  logic                   load_stall;
  cpu_isa_pkg::data_t     ex_operand_a;
  cpu_isa_pkg::data_t     ex_fwd_b;
  cpu_isa_pkg::data_t     ex_operand_b;
  cpu_isa_pkg::data_t     ex_result;
  logic                   ex_equal;
  cpu_isa_pkg::reg_idx_t  ex_dest;
  cpu_isa_pkg::jaddr_t    ex_jaddr;
  cpu_isa_pkg::addr_t     branch_target;
  cpu_isa_pkg::addr_t     redirect_pc;
  logic                   redirect;
  logic                   ex_mem_write_en;
  logic                   mem_wb_write_en;
  logic                   mem_op;
  logic                   mem_busy;
  bus_state_e             bus_state;
  cpu_isa_pkg::data_t     wb_data;

  //////////////////////////////////////////////////
  // fetch

  assign pc_plus4 = pc + 32'd4;

  instruction_memory imem_i (
    .pc          (pc),
    .instruction (fetch_inst)
  );

  //////////////////////////////////////////////////
  // decode

  assign id_rs  = if_id.instruction[cpu_isa_pkg::RS_LSB +: cpu_isa_pkg::REG_IDX_W];
  assign id_rt  = if_id.instruction[cpu_isa_pkg::RT_LSB +: cpu_isa_pkg::REG_IDX_W];
  assign id_rd  = if_id.instruction[cpu_isa_pkg::RD_LSB +: cpu_isa_pkg::REG_IDX_W];
  assign id_imm = if_id.instruction[0 +: cpu_isa_pkg::IMM_W];

  decode_unit decode_i (
    .instruction (if_id.instruction),
    .ctrl        (id_ctrl)
  );

  register_file regs_i (
    .clk         (clk),
    .reset       (reset),
    .write_en    (mem_wb_write_en),
    .write_idx   (mem_wb.dest),
    .write_data  (wb_data),
    .read_idx_1  (id_rs),
    .read_idx_2  (id_rt),
    .read_data_1 (reg_data_1),
    .read_data_2 (reg_data_2)
  );

  //////////////////////////////////////////////////
  // execute

  assign ex_mem_write_en = ex_mem.valid && ex_mem.ctrl.reg_write;
  assign ex_dest         = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

  hazard_forward_unit hazard_i (
    .id_ex_rs         (id_ex.rs),
    .id_ex_rt         (id_ex.rt),
    .ex_mem_dest      (ex_mem.dest),
    .mem_wb_dest      (mem_wb.dest),
    .ex_mem_reg_write (ex_mem_write_en),
    .mem_wb_reg_write (mem_wb_write_en),
    .id_ex_mem_read   (id_ex.valid && id_ex.ctrl.mem_read),
    .id_ex_dest       (ex_dest),
    .if_id_rs         (id_rs),
    .if_id_rt         (id_rt),
    .forward_a        (forward_a),
    .forward_b        (forward_b),
    .load_stall       (load_stall)
  );

  always_comb begin
    case (forward_a)
      cpu_pipe_pkg::EX_MEM: ex_operand_a = ex_mem.alu_result;
      cpu_pipe_pkg::MEM_WB: ex_operand_a = wb_data;
      default:              ex_operand_a = id_ex.rd_data_1;
    endcase
    case (forward_b)
      cpu_pipe_pkg::EX_MEM: ex_fwd_b = ex_mem.alu_result;
      cpu_pipe_pkg::MEM_WB: ex_fwd_b = wb_data;
      default:              ex_fwd_b = id_ex.rd_data_2;
    endcase
  end

  // store data is the forwarded rt, never the immediate
  assign ex_operand_b = id_ex.ctrl.alu_src ? id_ex.imm : ex_fwd_b;

  alu alu_i (
    .alu_op    (id_ex.ctrl.alu_op),
    .operand_a (ex_operand_a),
    .operand_b (ex_operand_b),
    .result    (ex_result),
    .equal     (ex_equal)
  );

  // the 26-bit jump field spans rs, rt and the immediate
  assign ex_jaddr      = {id_ex.rs, id_ex.rt, id_ex.imm[cpu_isa_pkg::IMM_W-1:0]};
  assign branch_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

  // halt spins on its own address so nothing younger gets past execute
  always_comb begin
    redirect    = 1'b0;
    redirect_pc = branch_target;
    if (id_ex.valid) begin
      if (id_ex.ctrl.jump) begin
        redirect    = 1'b1;
        redirect_pc = {id_ex.pc_plus4[31:28], ex_jaddr, 2'b00};
      end else if (id_ex.ctrl.halt) begin
        redirect    = 1'b1;
        redirect_pc = id_ex.pc_plus4 - 32'd4;
      end else if (id_ex.ctrl.branch && ex_equal) begin
        redirect = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // memory stage, wishbone master

  assign mem_op   = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
  assign mem_busy = mem_op && !(bus_state == BUS && wb_ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      bus_state <= IDLE;
      wb_req    <= '0;
    end else begin
      case (bus_state)
        IDLE: begin
          if (mem_op) begin
            wb_req.cyc   <= 1'b1;
            wb_req.stb   <= 1'b1;
            wb_req.we    <= ex_mem.ctrl.mem_write;
            wb_req.adr   <= ex_mem.alu_result;
            wb_req.dat_w <= ex_mem.store_data;
            bus_state    <= BUS;
          end
        end
        BUS: begin
          if (wb_ack) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            bus_state  <= DONE;
          end
        end
        // one idle cycle between bus cycles
        default: bus_state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // writeback

  assign mem_wb_write_en = mem_wb.valid && mem_wb.reg_write;
  assign wb_data         = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

  //////////////////////////////////////////////////
  // pc and pipeline registers

  // a pending bus access freezes every stage together
  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= cpu_isa_pkg::RESET_PC;
      if_id  <= '0;
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
      halted <= 1'b0;
    end else if (!mem_busy) begin
      // load data is sampled in the ack cycle
      mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
      mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= wb_dat_r;
      mem_wb.dest       <= ex_mem.dest;
      mem_wb.valid      <= ex_mem.valid;
      if (ex_mem.valid && ex_mem.ctrl.halt) begin
        halted <= 1'b1;
      end

      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.alu_result <= ex_result;
      ex_mem.store_data <= ex_fwd_b;
      ex_mem.dest       <= ex_dest;
      ex_mem.valid      <= id_ex.valid;

      if (redirect) begin
        // two bubbles behind a taken branch or jump
        pc    <= redirect_pc;
        if_id <= '0;
        id_ex <= '0;
      end else if (load_stall) begin
        id_ex <= '0;
      end else begin
        id_ex.ctrl      <= id_ctrl;
        id_ex.rd_data_1 <= reg_data_1;
        id_ex.rd_data_2 <= reg_data_2;
        id_ex.rs        <= id_rs;
        id_ex.rt        <= id_rt;
        id_ex.rd        <= id_rd;
        id_ex.imm       <= {{(cpu_isa_pkg::DATA_W-cpu_isa_pkg::IMM_W){id_imm[15]}}, id_imm};
        id_ex.pc_plus4  <= if_id.pc_plus4;
        id_ex.valid     <= if_id.valid;

        if_id.instruction <= fetch_inst;
        if_id.pc_plus4    <= pc_plus4;
        if_id.valid       <= !halted;
        if (!halted) begin
          pc <= pc_plus4;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  cpu_isa_pkg::alu_op_e alu_op,
  input  cpu_isa_pkg::data_t   operand_a,
  input  cpu_isa_pkg::data_t   operand_b,
  output cpu_isa_pkg::data_t   result,
  output logic                 equal
);

  always_comb begin
    case (alu_op)
      cpu_isa_pkg::ADD: result = operand_a + operand_b;
      cpu_isa_pkg::SUB: result = operand_a - operand_b;
      cpu_isa_pkg::AND: result = operand_a & operand_b;
      cpu_isa_pkg::OR:  result = operand_a | operand_b;
      // signed compare
      cpu_isa_pkg::SLT: begin
        result = ($signed(operand_a) < $signed(operand_b)) ? 32'd1 : 32'd0;
      end
      default: result = '0;
    endcase
  end

  // beq compares the two operands in execute
  assign equal = (operand_a == operand_b);

endmodule

`default_nettype wire

/* hazard_forward_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_forward_unit (
  input  cpu_isa_pkg::reg_idx_t  id_ex_rs,
  input  cpu_isa_pkg::reg_idx_t  id_ex_rt,
  input  cpu_isa_pkg::reg_idx_t  ex_mem_dest,
  input  cpu_isa_pkg::reg_idx_t  mem_wb_dest,
  input  logic                   ex_mem_reg_write,
  input  logic                   mem_wb_reg_write,
  input  logic                   id_ex_mem_read,
  input  cpu_isa_pkg::reg_idx_t  id_ex_dest,
  input  cpu_isa_pkg::reg_idx_t  if_id_rs,
  input  cpu_isa_pkg::reg_idx_t  if_id_rt,
  output cpu_pipe_pkg::fwd_sel_e forward_a,
  output cpu_pipe_pkg::fwd_sel_e forward_b,
  output logic                   load_stall
);

  logic ex_mem_fwd_ok;
  logic mem_wb_fwd_ok;

  // r0 is hardwired, a write to it must never be forwarded
  assign ex_mem_fwd_ok = ex_mem_reg_write && ex_mem_dest != '0;
  assign mem_wb_fwd_ok = mem_wb_reg_write && mem_wb_dest != '0;

  // the younger result in ex_mem wins over mem_wb
  always_comb begin
    forward_a = cpu_pipe_pkg::REG;
    if (ex_mem_fwd_ok && ex_mem_dest == id_ex_rs) forward_a = cpu_pipe_pkg::EX_MEM;
    else if (mem_wb_fwd_ok && mem_wb_dest == id_ex_rs) forward_a = cpu_pipe_pkg::MEM_WB;

    forward_b = cpu_pipe_pkg::REG;
    if (ex_mem_fwd_ok && ex_mem_dest == id_ex_rt) forward_b = cpu_pipe_pkg::EX_MEM;
    else if (mem_wb_fwd_ok && mem_wb_dest == id_ex_rt) forward_b = cpu_pipe_pkg::MEM_WB;
  end

  // load data only exists after the memory stage, so the user waits one cycle
  assign load_stall = id_ex_mem_read && id_ex_dest != '0 &&
                      (id_ex_dest == if_id_rs || id_ex_dest == if_id_rt);

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  write_en,
  input  cpu_isa_pkg::reg_idx_t write_idx,
  input  cpu_isa_pkg::data_t    write_data,
  input  cpu_isa_pkg::reg_idx_t read_idx_1,
  input  cpu_isa_pkg::reg_idx_t read_idx_2,
  output cpu_isa_pkg::data_t    read_data_1,
  output cpu_isa_pkg::data_t    read_data_2
);

  cpu_isa_pkg::data_t regs [32];

  // r0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (write_en && write_idx != '0) begin
      regs[write_idx] <= write_data;
    end
  end

  // write-through covers the writer three instructions ahead
  assign read_data_1 = (read_idx_1 == '0) ? '0 :
                       (write_en && write_idx == read_idx_1) ? write_data :
                       regs[read_idx_1];
  assign read_data_2 = (read_idx_2 == '0) ? '0 :
                       (write_en && write_idx == read_idx_2) ? write_data :
                       regs[read_idx_2];

endmodule

`default_nettype wire

/* decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
  input  cpu_isa_pkg::inst_t  instruction,
  output cpu_pipe_pkg::ctrl_t ctrl
);

  cpu_isa_pkg::opcode_e opcode;

  // register-register ops differ only in the alu operation
  function automatic cpu_pipe_pkg::ctrl_t r_type(input cpu_isa_pkg::alu_op_e op);
    cpu_pipe_pkg::ctrl_t c;
    c           = '0;
    c.reg_write = 1'b1;
    c.reg_dst   = 1'b1;
    c.alu_op    = op;
    return c;
  endfunction

  assign opcode = cpu_isa_pkg::opcode_e'(
    instruction[cpu_isa_pkg::OPCODE_LSB +: cpu_isa_pkg::OPCODE_W]);

  always_comb begin
    ctrl = '0;
    case (opcode)
      cpu_isa_pkg::OP_ADD: ctrl = r_type(cpu_isa_pkg::ADD);
      cpu_isa_pkg::OP_SUB: ctrl = r_type(cpu_isa_pkg::SUB);
      cpu_isa_pkg::OP_AND: ctrl = r_type(cpu_isa_pkg::AND);
      cpu_isa_pkg::OP_OR:  ctrl = r_type(cpu_isa_pkg::OR);
      cpu_isa_pkg::OP_SLT: ctrl = r_type(cpu_isa_pkg::SLT);
      cpu_isa_pkg::OP_ADDI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      cpu_isa_pkg::OP_LW: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      cpu_isa_pkg::OP_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      cpu_isa_pkg::OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = cpu_isa_pkg::SUB;
      end
      cpu_isa_pkg::OP_J:    ctrl.jump = 1'b1;
      cpu_isa_pkg::OP_HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* instruction_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module instruction_memory (
  input  cpu_isa_pkg::addr_t pc,
  output cpu_isa_pkg::inst_t instruction
);

  cpu_isa_pkg::inst_t rom [cpu_isa_pkg::IMEM_WORDS];
  logic               in_range;

  // words past the end of program.hex read as no-ops
  initial begin
    for (int i = 0; i < cpu_isa_pkg::IMEM_WORDS; i++) begin
      rom[i] = '0;
    end
    $readmemh("program.hex", rom);
  end

  // byte offset bits are dropped, anything above the rom depth is out of range
  assign in_range = (pc[cpu_isa_pkg::DATA_W-1:cpu_isa_pkg::IMEM_IDX_W+2] == '0);
  assign instruction = in_range ? rom[pc[cpu_isa_pkg::IMEM_IDX_W+1:2]] : '0;

endmodule

`default_nettype wire

/* cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

  typedef struct packed {
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_to_reg;
    logic                 alu_src;
    logic                 reg_dst;
    logic                 branch;
    logic                 jump;
    logic                 halt;
    cpu_isa_pkg::alu_op_e alu_op;
  } ctrl_t;

  //////////////////////////////////////////////////
  // pipeline registers

  typedef struct packed {
    cpu_isa_pkg::inst_t instruction;
    cpu_isa_pkg::addr_t pc_plus4;
    logic               valid;
  } if_id_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    cpu_isa_pkg::data_t    rd_data_1;
    cpu_isa_pkg::data_t    rd_data_2;
    cpu_isa_pkg::reg_idx_t rs;
    cpu_isa_pkg::reg_idx_t rt;
    cpu_isa_pkg::reg_idx_t rd;
    cpu_isa_pkg::data_t    imm;
    cpu_isa_pkg::addr_t    pc_plus4;
    logic                  valid;
  } id_ex_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    cpu_isa_pkg::data_t    alu_result;
    cpu_isa_pkg::data_t    store_data;
    cpu_isa_pkg::reg_idx_t dest;
    logic                  valid;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    cpu_isa_pkg::data_t    alu_result;
    cpu_isa_pkg::data_t    load_data;
    cpu_isa_pkg::reg_idx_t dest;
    logic                  valid;
  } mem_wb_t;

  // operand source for the alu inputs
  typedef enum logic [1:0] {
    REG    = 2'b00,
    MEM_WB = 2'b01,
    EX_MEM = 2'b10
  } fwd_sel_e;

  // wishbone classic master outputs
  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    cpu_isa_pkg::addr_t adr;
    cpu_isa_pkg::data_t dat_w;
  } wb_req_t;

endpackage

`default_nettype wire

/* cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

  // instruction field widths and bit positions
  localparam int DATA_W     = 32;
  localparam int OPCODE_W   = 6;
  localparam int REG_IDX_W  = 5;
  localparam int IMM_W      = 16;
  localparam int JADDR_W    = 26;
  localparam int OPCODE_LSB = 26;
  localparam int RS_LSB     = 21;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [DATA_W-1:0]    inst_t;
  typedef logic [DATA_W-1:0]    addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [IMM_W-1:0]     imm_t;
  typedef logic [JADDR_W-1:0]   jaddr_t;

  // instruction rom depth and the fetch start address
  localparam int    IMEM_WORDS = 64;
  localparam int    IMEM_IDX_W = $clog2(IMEM_WORDS);
  localparam addr_t RESET_PC   = '0;

  // opcode 0 doubles as the no-op (add r0, r0, r0)
  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD  = 6'h00,
    OP_SUB  = 6'h01,
    OP_AND  = 6'h02,
    OP_OR   = 6'h03,
    OP_SLT  = 6'h04,
    OP_ADDI = 6'h08,
    OP_BEQ  = 6'h10,
    OP_J    = 6'h12,
    OP_LW   = 6'h23,
    OP_SW   = 6'h2b,
    OP_HALT = 6'h3f
  } opcode_e;

  typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} alu_op_e;

endpackage

`default_nettype wire
